/* design/qpix_timing_pkg.sv */
`default_nettype none

////////////////////
// cycle counts and counter widths for the pad sequencers
////////////////////

package qpix_timing_pkg;

    // sequencer counters count elapsed high cycles of an enable
    localparam int SEQ_COUNT_WIDTH = 9;

    // wide enough for the longest sequence, which is 255 cycles
    typedef logic [SEQ_COUNT_WIDTH-1:0] seq_count_t;

    // cal_control pulse length during calibration, 5 us at 50 MHz
    localparam seq_count_t CAL_CONTROL_CYCLES = 9'd250;

    // RST_EXT outlasts cal_control by 100 ns
    localparam seq_count_t CAL_RST_EXT_CYCLES = 9'd255;

    // chip reset length before the trigger is handed over
    localparam seq_count_t RST_TRIG_CYCLES = 9'd250;

    ////////////////////
    // timestamp
    ////////////////////

    // free-running counter, never expected to wrap in practice
    localparam int TIMESTAMP_WIDTH = 64;

    typedef logic [TIMESTAMP_WIDTH-1:0] timestamp_t;

endpackage

`default_nettype wire

/* design/qpix_pad_pkg.sv */
`default_nettype none

////////////////////
// pad-side definitions for the two-chip board
////////////////////

package qpix_pad_pkg;

    // one QPix ASIC per socket, two sockets on the board
    localparam int NUM_ASICS = 2;

    // one bit per chip
    // bit 0 drives the first chip's pad, bit 1 the second chip's pad
    typedef logic [NUM_ASICS-1:0] asic_pads_t;

endpackage

`default_nettype wire

/* design/cal_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

// calibration sequence
// cal_control and RST_EXT rise together, cal_control drops after 250 cycles
// and RST_EXT follows 5 cycles (100 ns) later
module cal_sequencer (
    input  wire logic clk,
    input  wire logic counter_reset,
    input  wire logic calibrate,
    output logic      cal_pulse,
    output logic      cal_rst
);

    typedef enum logic [1:0]
    {
        IDLE,
        PULSE,
        DONE
    } cal_state_t;

    cal_state_t                 state;
    // number of high cycles of calibrate seen since the pulse started
    qpix_timing_pkg::seq_count_t count;

    ////////////////////
    // sequencer FSM
    ////////////////////

    always_ff @(posedge clk)
    begin
        // dropping calibrate restarts the sequence from IDLE
        if (counter_reset || !calibrate)
        begin
            state     <= IDLE;
            count     <= '0;
            cal_pulse <= 1'b0;
            cal_rst   <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    // first edge with calibrate high, both pulses start here
                    state     <= PULSE;
                    count     <= qpix_timing_pkg::seq_count_t'(1);
                    cal_pulse <= 1'b1;
                    cal_rst   <= 1'b1;
                end
                PULSE:
                begin
                    // cal_control ends first
                    if (count == qpix_timing_pkg::CAL_CONTROL_CYCLES)
                        cal_pulse <= 1'b0;
                    // then RST_EXT, counter stops at its terminal count
                    if (count == qpix_timing_pkg::CAL_RST_EXT_CYCLES)
                    begin
                        cal_rst <= 1'b0;
                        state   <= DONE;
                    end
                    else
                        count <= count + qpix_timing_pkg::seq_count_t'(1);
                end
                DONE:
                begin
                    // wait here with outputs low until calibrate drops
                    cal_pulse <= 1'b0;
                    cal_rst   <= 1'b0;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/rst_trig_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

// reset-then-trigger sequence
// holds RST_EXT for 250 cycles, then raises TRIGGER for the external
// arbiter and keeps it up while rst_and_trig stays high
module rst_trig_sequencer (
    input  wire logic clk,
    input  wire logic counter_reset,
    input  wire logic rst_and_trig,
    output logic      seq_rst,
    output logic      seq_trig
);

    typedef enum logic [1:0]
    {
        IDLE,
        RESET,
        TRIGGER
    } rst_trig_state_t;

    rst_trig_state_t             state;
    // high cycles of rst_and_trig spent in the reset phase
    qpix_timing_pkg::seq_count_t count;

    ////////////////////
    // sequencer FSM
    ////////////////////

    always_ff @(posedge clk)
    begin
        // enable low means idle, and a new enable starts over
        if (counter_reset || !rst_and_trig)
        begin
            state    <= IDLE;
            count    <= '0;
            seq_rst  <= 1'b0;
            seq_trig <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    state   <= RESET;
                    count   <= qpix_timing_pkg::seq_count_t'(1);
                    seq_rst <= 1'b1;
                end
                RESET:
                begin
                    // reset ends and trigger starts on the same edge
                    if (count == qpix_timing_pkg::RST_TRIG_CYCLES)
                    begin
                        seq_rst  <= 1'b0;
                        seq_trig <= 1'b1;
                        state    <= TRIGGER;
                    end
                    else
                        count <= count + qpix_timing_pkg::seq_count_t'(1);
                end
                TRIGGER:
                    // counter holds at terminal count
                    seq_trig <= 1'b1;
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/pad_and_timestamp.sv */
`timescale 1ns/10ps
`default_nettype none

// output stage for the chip pads plus the trigger timestamp
// manual register levels are ORed with the sequencer results
// and every pad leaves through a flop
module pad_and_timestamp (
    input  wire logic                       clk,
    input  wire logic                       counter_reset,
    // sequencer results
    input  wire logic                       cal_pulse,
    input  wire logic                       cal_rst,
    input  wire logic                       seq_rst,
    input  wire logic                       seq_trig,
    // manual levels, one bit per chip where it applies
    input  wire qpix_pad_pkg::asic_pads_t   cal_control_reg,
    input  wire qpix_pad_pkg::asic_pads_t   rst_ext_reg,
    input  wire logic                       trigger_level,
    // pads
    output qpix_pad_pkg::asic_pads_t        cal_control,
    output qpix_pad_pkg::asic_pads_t        rst_ext,
    output logic                            trigger,
    // counter value captured at the last trigger_level rise
    output qpix_timing_pkg::timestamp_t     trig_ts
);

    qpix_pad_pkg::asic_pads_t    cal_pulse_all;
    qpix_pad_pkg::asic_pads_t    rst_seq_all;
    qpix_timing_pkg::timestamp_t counter;
    logic                        trigger_level_q;
    logic                        trigger_rise;

    ////////////////////
    // pad merge
    ////////////////////

    // the sequencers drive both chips alike
    assign cal_pulse_all = {qpix_pad_pkg::NUM_ASICS{cal_pulse}};
    // calibration and reset-then-trigger share RST_EXT
    assign rst_seq_all   = {qpix_pad_pkg::NUM_ASICS{cal_rst | seq_rst}};

    always_ff @(posedge clk)
    begin
        if (counter_reset)
        begin
            cal_control <= '0;
            rst_ext     <= '0;
            trigger     <= 1'b0;
        end
        else
        begin
            // per chip, the manual bit or the calibration pulse
            cal_control <= cal_control_reg | cal_pulse_all;
            rst_ext     <= rst_ext_reg | rst_seq_all;
            // TRIGGER is shared by both chips
            trigger     <= trigger_level | seq_trig;
        end
    end

    ////////////////////
    // timestamp
    ////////////////////

    // free counter, one tick per clk
    always_ff @(posedge clk)
    begin
        if (counter_reset)
            counter <= '0;
        else
            counter <= counter + qpix_timing_pkg::timestamp_t'(1);
    end

    // previous sample of the manual trigger level
    always_ff @(posedge clk)
    begin
        trigger_level_q <= trigger_level;
    end

    // high sample now after a low sample last edge
    assign trigger_rise = trigger_level & ~trigger_level_q;

    // capture the count held just before the rising sample
    always_ff @(posedge clk)
    begin
        if (counter_reset)
            trig_ts <= '0;
        else if (trigger_rise)
            trig_ts <= counter;
    end

endmodule

`default_nettype wire

/* design/qpix_pad_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

// pad sequencing and trigger timestamp core for the two-chip test board
// two sequencers run side by side and the output stage merges them
// with the manual register levels
module qpix_pad_ctrl (
    input  wire logic                       clk,
    input  wire logic                       counter_reset,
    // sequence enables, held as levels
    input  wire logic                       calibrate,
    input  wire logic                       rst_and_trig,
    // manual pad levels
    input  wire qpix_pad_pkg::asic_pads_t   cal_control_reg,
    input  wire qpix_pad_pkg::asic_pads_t   rst_ext_reg,
    input  wire logic                       trigger_level,
    // pads to the chips
    output wire qpix_pad_pkg::asic_pads_t   cal_control,
    output wire qpix_pad_pkg::asic_pads_t   rst_ext,
    output wire logic                       trigger,
    output wire qpix_timing_pkg::timestamp_t trig_ts
);

    // calibration results
    logic cal_pulse;
    logic cal_rst;
    // reset-then-trigger results
    logic seq_rst;
    logic seq_trig;

    ////////////////////
    // sequencers
    ////////////////////

    cal_sequencer u_cal_seq (
        .clk           (clk),
        .counter_reset (counter_reset),
        .calibrate     (calibrate),
        .cal_pulse     (cal_pulse),
        .cal_rst       (cal_rst)
    );

    rst_trig_sequencer u_rst_trig_seq (
        .clk           (clk),
        .counter_reset (counter_reset),
        .rst_and_trig  (rst_and_trig),
        .seq_rst       (seq_rst),
        .seq_trig      (seq_trig)
    );

    ////////////////////
    // output stage
    ////////////////////

    // one more register stage between the sequencers and the pads
    pad_and_timestamp u_pad_ts (
        .clk             (clk),
        .counter_reset   (counter_reset),
        .cal_pulse       (cal_pulse),
        .cal_rst         (cal_rst),
        .seq_rst         (seq_rst),
        .seq_trig        (seq_trig),
        .cal_control_reg (cal_control_reg),
        .rst_ext_reg     (rst_ext_reg),
        .trigger_level   (trigger_level),
        .cal_control     (cal_control),
        .rst_ext         (rst_ext),
        .trigger         (trigger),
        .trig_ts         (trig_ts)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

// free-running testbench clock, 100 ns period
module tb_clock_gen (
    output logic clk
);

    // half of the 100 ns period
    localparam int half_period_ns = 50;

    ////////////////////
    // clock
    ////////////////////

    // starts low, first rising edge at 50 ns
    initial
    begin
        clk = 1'b0;
        forever
            #half_period_ns clk = ~clk;
    end

endmodule

`default_nettype wire

/* verif/qpix_pad_ctrl_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module qpix_pad_ctrl_tb;

    localparam int num_tests    = 6;
    localparam int reset_cycles = 5;
    localparam int tail_cycles  = 5;
    localparam int idle_timeout = 20;

    // test kinds in the table
    localparam int kind_reset     = 0;
    localparam int kind_pulse     = 1;
    localparam int kind_manual    = 2;
    localparam int kind_timestamp = 3;
    localparam int kind_restart   = 4;

    logic                        clk;
    logic                        counter_reset;
    logic                        calibrate;
    logic                        rst_and_trig;
    qpix_pad_pkg::asic_pads_t    cal_control_reg;
    qpix_pad_pkg::asic_pads_t    rst_ext_reg;
    logic                        trigger_level;
    qpix_pad_pkg::asic_pads_t    cal_control;
    qpix_pad_pkg::asic_pads_t    rst_ext;
    logic                        trigger;
    qpix_timing_pkg::timestamp_t trig_ts;

    ////////////////////
    // stimulus table
    ////////////////////

    string test_name [num_tests];
    int    test_kind [num_tests];
    logic  test_cal  [num_tests];
    logic  test_rat  [num_tests];
    // enable hold length, or the loop length for manual and timestamp tests
    int    test_hold [num_tests];
    // expected high cycles on cal_control and rst_ext
    int    exp_cal   [num_tests];
    int    exp_rst   [num_tests];
    // trigger edge k for the timestamp test, drop point for the restart test
    int    test_arg  [num_tests];

    // pad trackers, bits 0..1 cal_control, 2..3 rst_ext, 4 trigger
    int         first_hi [5];
    int         last_hi  [5];
    int         hi_cnt   [5];
    int         rises    [5];
    logic [4:0] prev_pads;

    int error_count;
    int check_count;
    int failed_tests;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    qpix_pad_ctrl u_dut (
        .clk             (clk),
        .counter_reset   (counter_reset),
        .calibrate       (calibrate),
        .rst_and_trig    (rst_and_trig),
        .cal_control_reg (cal_control_reg),
        .rst_ext_reg     (rst_ext_reg),
        .trigger_level   (trigger_level),
        .cal_control     (cal_control),
        .rst_ext         (rst_ext),
        .trigger         (trigger),
        .trig_ts         (trig_ts)
    );

    ////////////////////
    // helpers
    ////////////////////

    task automatic check_value(input string test, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            error_count++;
            $display("FAILED %s %s: expected %0d, actual %0d", test, what, expected, actual);
        end
    endtask

    task automatic set_entry(input int idx, input string name, input int kind,
                             input logic cal, input logic rat, input int hold,
                             input int ecal, input int erst, input int arg);
        test_name[idx] = name;
        test_kind[idx] = kind;
        test_cal[idx]  = cal;
        test_rat[idx]  = rat;
        test_hold[idx] = hold;
        exp_cal[idx]   = ecal;
        exp_rst[idx]   = erst;
        test_arg[idx]  = arg;
    endtask

    // pulse lengths come straight from the 250/255/250 cycle sequence rules
    task automatic load_test_table();
        set_entry(0, "reset_values",        kind_reset,     0, 0, 5,   0,   0,   0);
        set_entry(1, "calibration",         kind_pulse,     1, 0, 300, 250, 255, 0);
        set_entry(2, "reset_then_trigger",  kind_pulse,     0, 1, 400, 0,   250, 0);
        set_entry(3, "manual_levels",       kind_manual,    0, 0, 40,  0,   0,   0);
        set_entry(4, "timestamp",           kind_timestamp, 0, 0, 60,  0,   0,   37);
        set_entry(5, "calibration_restart", kind_restart,   1, 0, 300, 250, 255, 100);
    endtask

    // all inputs low, called on a falling edge
    task automatic drive_idle();
        calibrate       = 1'b0;
        rst_and_trig    = 1'b0;
        cal_control_reg = '0;
        rst_ext_reg     = '0;
        trigger_level   = 1'b0;
    endtask

    task automatic wait_pads_idle(input int t);
        int   waited;
        logic idle;
        waited = 0;
        idle   = 1'b0;
        while (!idle && waited < idle_timeout)
        begin
            @(negedge clk);
            waited++;
            idle = (cal_control == '0) && (rst_ext == '0) && !trigger;
        end
        if (!idle)
        begin
            error_count++;
            $display("ERROR %s: pads still active %0d cycles after all inputs went low",
                     test_name[t], idle_timeout);
        end
    endtask

    task automatic clear_trackers();
        for (int s = 0; s < 5; s++)
        begin
            first_hi[s] = -1;
            last_hi[s]  = -1;
            hi_cnt[s]   = 0;
            rises[s]    = 0;
        end
        prev_pads = '0;
    endtask

    // sample idx is taken on the falling edge after the idx-th rising edge
    task automatic track_pads(input int idx);
        logic [4:0] now;
        now = {trigger, rst_ext, cal_control};
        for (int s = 0; s < 5; s++)
        begin
            if (now[s])
            begin
                hi_cnt[s]++;
                last_hi[s] = idx;
                if (first_hi[s] < 0)
                    first_hi[s] = idx;
                if (!prev_pads[s])
                    rises[s]++;
            end
        end
        prev_pads = now;
    endtask

    task automatic measure_pads(input int first, input int count);
        for (int i = 0; i < count; i++)
        begin
            @(negedge clk);
            track_pads(first + i);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic run_reset_test(input int t);
        for (int i = 0; i < test_hold[t]; i++)
        begin
            check_value(test_name[t], "cal_control", 64'(0), 64'(cal_control));
            check_value(test_name[t], "rst_ext", 64'(0), 64'(rst_ext));
            check_value(test_name[t], "trigger", 64'(0), 64'(trigger));
            check_value(test_name[t], "trig_ts", 64'(0), 64'(trig_ts));
            @(negedge clk);
        end
    endtask

    task automatic run_pulse_test(input int t);
        int expected;
        clear_trackers();
        calibrate    = test_cal[t];
        rst_and_trig = test_rat[t];
        measure_pads(1, test_hold[t]);
        // release, then watch the pads settle
        calibrate    = 1'b0;
        rst_and_trig = 1'b0;
        measure_pads(test_hold[t] + 1, tail_cycles);
        for (int s = 0; s < 4; s++)
        begin
            expected = (s < 2) ? exp_cal[t] : exp_rst[t];
            if (expected > 0)
            begin
                // pads rise two edges after the drive, one clean pulse
                check_value(test_name[t], $sformatf("pad %0d first high", s), 64'(2),
                            64'(first_hi[s]));
                check_value(test_name[t], $sformatf("pad %0d high cycles", s), 64'(expected),
                            64'(hi_cnt[s]));
                check_value(test_name[t], $sformatf("pad %0d pulses", s), 64'(1),
                            64'(rises[s]));
            end
            else
                check_value(test_name[t], $sformatf("pad %0d high cycles", s), 64'(0),
                            64'(hi_cnt[s]));
        end
        if (test_rat[t])
        begin
            // trigger takes over on the edge where rst_ext falls
            check_value(test_name[t], "trigger first high", 64'(exp_rst[t] + 2),
                        64'(first_hi[4]));
            // and drops two edges after release
            check_value(test_name[t], "trigger last high", 64'(test_hold[t] + 1),
                        64'(last_hi[4]));
            check_value(test_name[t], "trigger pulses", 64'(1), 64'(rises[4]));
        end
        else
            check_value(test_name[t], "trigger high cycles", 64'(0), 64'(hi_cnt[4]));
    endtask

    task automatic run_manual_test(input int t);
        logic [31:0]              rnd;
        qpix_pad_pkg::asic_pads_t exp_cc;
        qpix_pad_pkg::asic_pads_t exp_re;
        logic                     exp_tr;
        for (int i = 0; i <= test_hold[t]; i++)
        begin
            if (i > 0)
            begin
                @(negedge clk);
                // each pad shows its level one cycle later
                check_value(test_name[t], "cal_control", 64'(exp_cc), 64'(cal_control));
                check_value(test_name[t], "rst_ext", 64'(exp_re), 64'(rst_ext));
                check_value(test_name[t], "trigger", 64'(exp_tr), 64'(trigger));
            end
            rnd             = $urandom;
            exp_cc          = rnd[1:0];
            exp_re          = rnd[3:2];
            exp_tr          = rnd[4];
            cal_control_reg = exp_cc;
            rst_ext_reg     = exp_re;
            trigger_level   = exp_tr;
        end
        drive_idle();
    endtask

    task automatic run_timestamp_test(input int t);
        int fall;
        int k;
        int m;
        k = test_arg[t];
        m = test_hold[t];
        counter_reset = 1'b1;
        @(negedge clk);
        // first falling edge after the reset-sampling edge counts as 1
        counter_reset = 1'b0;
        fall = 1;
        for (int i = 1; i < k; i++)
        begin
            @(negedge clk);
            fall++;
        end
        check_value(test_name[t], "trig_ts before trigger", 64'(0), 64'(trig_ts));
        trigger_level = 1'b1;
        for (int i = 0; i < m - k; i++)
        begin
            @(negedge clk);
            fall++;
            // holds its value while the level stays up and after it drops
            check_value(test_name[t], "trig_ts first capture", 64'(k - 1), 64'(trig_ts));
            if (fall == k + 5)
                trigger_level = 1'b0;
        end
        trigger_level = 1'b1;
        @(negedge clk);
        check_value(test_name[t], "trig_ts second capture", 64'(m - 1), 64'(trig_ts));
        trigger_level = 1'b0;
    endtask

    task automatic run_restart_test(input int t);
        calibrate = 1'b1;
        for (int i = 0; i < test_arg[t]; i++)
            @(negedge clk);
        // drop calibrate in mid pulse
        calibrate = 1'b0;
        @(negedge clk);
        check_value(test_name[t], "cal_control one edge after drop", 64'(3), 64'(cal_control));
        check_value(test_name[t], "rst_ext one edge after drop", 64'(3), 64'(rst_ext));
        @(negedge clk);
        check_value(test_name[t], "cal_control two edges after drop", 64'(0), 64'(cal_control));
        check_value(test_name[t], "rst_ext two edges after drop", 64'(0), 64'(rst_ext));
        // a fresh enable gives a full sequence again
        run_pulse_test(t);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin
        int errors_before;
        // every input active while reset is held
        // the pads and trig_ts still have to read zero after reset
        counter_reset   = 1'b1;
        calibrate       = 1'b1;
        rst_and_trig    = 1'b1;
        cal_control_reg = '1;
        rst_ext_reg     = '1;
        trigger_level   = 1'b1;
        error_count  = 0;
        check_count  = 0;
        failed_tests = 0;
        void'($urandom(68));
        load_test_table();
        for (int i = 0; i < reset_cycles; i++)
            @(posedge clk);
        @(negedge clk);
        counter_reset = 1'b0;
        for (int t = 0; t < num_tests; t++)
        begin
            errors_before = error_count;
            drive_idle();
            if (test_kind[t] != kind_reset)
                wait_pads_idle(t);
            case (test_kind[t])
                kind_reset:     run_reset_test(t);
                kind_pulse:     run_pulse_test(t);
                kind_manual:    run_manual_test(t);
                kind_timestamp: run_timestamp_test(t);
                kind_restart:   run_restart_test(t);
                default:
                begin
                    error_count++;
                    $display("ERROR %s: unknown test kind in the table", test_name[t]);
                end
            endcase
            if (error_count == errors_before)
                $display("PASS %s", test_name[t]);
            else
            begin
                failed_tests++;
                $display("FAIL %s with %0d errors", test_name[t], error_count - errors_before);
            end
        end
        $display("%0d tests, %0d with errors, %0d compares, %0d mismatches",
                 num_tests, failed_tests, check_count, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* qpix_pad_ctrl.f */
design/qpix_timing_pkg.sv
design/qpix_pad_pkg.sv
design/cal_sequencer.sv
design/rst_trig_sequencer.sv
design/pad_and_timestamp.sv
design/qpix_pad_ctrl.sv
verif/tb_clock_gen.sv
verif/qpix_pad_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the qpix_pad_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=qpix_pad_ctrl_tb

verilator --binary --timing \
    -f qpix_pad_ctrl.f \
    --top-module qpix_pad_ctrl_tb \
    -Mdir "$build_dir" \
    -o "$sim_bin"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$("./$build_dir/$sim_bin")
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints the pass message on a line of its own
if printf '%s\n' "$output" | grep -qx "All checks passed"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
